// ==== src/mac_settings.svh ====
// ========================================
// Mac board settings
// Sizes, offsets and counts shared by the
// system glue and the image loader
// ========================================
`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// Reset hold, counted in cen pulses
`define MAC_RST_LEN 65535

// Activity light hold in clk_sys cycles
`define MAC_LED_HOLD 1000000

// Block device acks to wait before turbo may engage
`define MAC_TURBO_ACKS 20

// Floppy image sizes in words (819200 and 409600 bytes)
`define MAC_FLOPPY_DS_WORDS 409600
`define MAC_FLOPPY_SS_WORDS 204800

// Disk images sit right after the OS ROM
`define MAC_FLOPPY0_BASE 'h80000
`define MAC_FLOPPY1_BASE 'h100000

// Top nibble of the SDRAM address for ROM and downloads
`define MAC_ROM_REGION 4'b0001

`endif

// ==== src/mac_pkg.sv ====
// ========================================
// Mac board package
// Types for download targets, memory size
// and word addresses
// ========================================
package mac_pkg;

	// ========================================
	// Download targets
	// ========================================

	// Index values as sent by the host menu
	typedef enum logic [7:0] {
		DL_OS_ROM      = 8'd0,
		DL_FLOPPY_INT  = 8'd1,
		DL_FLOPPY_EXT  = 8'd2
	} dl_target_e;

	// ========================================
	// Memory and addresses
	// ========================================

	// Memory size code
	// 0 128KB, 1 512KB, 2 1MB, 3 4MB
	typedef logic [1:0] mem_size_t;

	// Download address in 16-bit words
	typedef logic [23:0] word_addr_t;

	// SDRAM port word address
	// bit 21 selects the ROM region
	typedef logic [24:0] sdram_addr_t;

endpackage

// ==== src/mem_req_if.sv ====
// ========================================
// Loader memory request
// Word writes from the image loader to the
// SDRAM arbiter
// ========================================
`timescale 1ns/1ps

interface mem_req_if;
	import mac_pkg::*;

	// Word address inside the SDRAM
	sdram_addr_t addr;
	logic [15:0] wdata;
	// Byte enables, upper then lower
	logic [1:0]  ds;
	// One strobe per word
	logic        we;
	// Download owns the port this cycle
	logic        active;

	modport loader (output addr, wdata, ds, we, active);
	modport arbiter (input addr, wdata, ds, we, active);

endinterface

// ==== src/mac_sys_ctrl.sv ====
// ========================================
// System control
// Clock enables, reset sequencer with memory
// size latch, delayed turbo and disk light
// ========================================
`include "mac_settings.svh"
`timescale 1ns/1ps

module mac_sys_ctrl #(
	parameter int unsigned RST_LEN  = `MAC_RST_LEN,
	parameter int unsigned LED_HOLD = `MAC_LED_HOLD
) (
	input  logic              clk_sys,
	input  logic              n_reset,
	input  logic              reset_req,
	input  mac_pkg::mem_size_t mem_size,
	input  logic              turbo_req,
	input  logic              dio_slot,
	input  logic              sd_ack,
	input  logic [1:0]        disk_motor,
	input  logic [1:0]        disk_act,
	input  logic              ioctl_download,
	output logic              cep,
	output logic              cen,
	output logic              ce_pixel,
	output logic              sys_reset_n,
	output mac_pkg::mem_size_t ram_size,
	output logic              turbo,
	output logic              led_user
);
	import mac_pkg::*;

	localparam int RST_W  = $clog2(RST_LEN + 1);
	localparam int LED_W  = $clog2(LED_HOLD + 1);
	localparam int TURBO_W = $clog2(`MAC_TURBO_ACKS + 1);

	logic [2:0]         div;
	logic [RST_W-1:0]   rst_cnt;
	logic [TURBO_W-1:0] ack_cnt;
	logic               sd_ack_q;
	logic [LED_W-1:0]   led_cnt;

	// ========================================
	// Clock enables
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!n_reset)
			div <= '0;
		else
			div <= div + 3'd1;
	end

	// CPU phases half a period apart, pixel at twice the rate
	assign cep      = (div == 3'd0);
	assign cen      = (div == 3'd4);
	assign ce_pixel = (div[1:0] == 2'b00);

	// ========================================
	// Reset sequencer
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!n_reset || reset_req) begin
			rst_cnt     <= RST_W'(RST_LEN);
			sys_reset_n <= 1'b0;
		end else if (rst_cnt != '0) begin
			if (cen)
				rst_cnt <= rst_cnt - 1'b1;
		end else if (cen) begin
			// Release on a CPU phase
			sys_reset_n <= 1'b1;
		end
	end

	// Size menu starts one step above the smallest model
	always_ff @(posedge clk_sys) begin
		if (rst_cnt != '0)
			ram_size <= mem_size_t'(mem_size + 2'd1);
	end

	// ========================================
	// Turbo delay
	// ========================================
	// SCSI boot fails at full speed, so hold turbo off for a few block acks
	always_ff @(posedge clk_sys) begin
		if (!n_reset || !sys_reset_n) begin
			ack_cnt  <= TURBO_W'(`MAC_TURBO_ACKS);
			sd_ack_q <= 1'b0;
			turbo    <= 1'b0;
		end else begin
			sd_ack_q <= sd_ack;
			if (sd_ack_q && !sd_ack && ack_cnt != '0)
				ack_cnt <= ack_cnt - 1'b1;
			// Floppy in use, start the delay over
			if (|disk_motor)
				ack_cnt <= TURBO_W'(`MAC_TURBO_ACKS);
			// Switch only between chipset cycles
			if (ack_cnt == '0 && dio_slot)
				turbo <= turbo_req;
		end
	end

	// ========================================
	// Activity light
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!n_reset)
			led_cnt <= '0;
		else if (|disk_act)
			led_cnt <= LED_W'(LED_HOLD);
		else if (led_cnt != '0)
			led_cnt <= led_cnt - 1'b1;
	end

	// Running motor flips the light so activity still blinks
	assign led_user = ioctl_download || ((led_cnt != '0) ^ (|disk_motor));

	// CPU phases never overlap
	a_cep_cen: assert property (@(posedge clk_sys) disable iff (!n_reset)
		!(cep && cen))
		else $error("cep and cen high together");

endmodule

// ==== src/rom_loader.sv ====
// ========================================
// ROM and disk image loader
// Packs download bytes into words, maps each
// image into SDRAM and paces the host
// ========================================
`include "mac_settings.svh"
`timescale 1ns/1ps

module rom_loader (
	input  logic                clk_sys,
	input  logic                n_reset,
	input  logic                ioctl_download,
	input  mac_pkg::dl_target_e ioctl_index,
	input  logic                ioctl_wr,
	input  logic [24:0]         ioctl_addr,
	input  logic [7:0]          ioctl_data,
	input  logic                dio_slot,
	output logic                ioctl_wait,
	mem_req_if.loader           req,
	output logic                dl_end,
	output mac_pkg::dl_target_e dl_index,
	output mac_pkg::word_addr_t dl_words
);
	import mac_pkg::*;

	logic [7:0]  byte_hi;
	logic [15:0] word_data;
	word_addr_t  word_addr;
	logic [20:0] dio_a;
	logic        write_pend;
	logic        slot_q;
	logic        download_q;

	// ========================================
	// Byte pairing
	// ========================================
	// Even byte is the high half, odd byte completes the word
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr && ioctl_download) begin
			if (!ioctl_addr[0]) begin
				byte_hi <= ioctl_data;
			end else begin
				word_data <= {byte_hi, ioctl_data};
				word_addr <= ioctl_addr[24:1];
			end
		end
	end

	// ========================================
	// Wait handshake
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			ioctl_wait <= 1'b0;
			write_pend <= 1'b0;
			slot_q     <= 1'b0;
		end else begin
			slot_q <= dio_slot;
			if (ioctl_wr && ioctl_download && ioctl_addr[0])
				ioctl_wait <= 1'b1;
			// Slot just ended with the word written, release the host
			if (slot_q && !dio_slot && write_pend) begin
				ioctl_wait <= 1'b0;
				write_pend <= 1'b0;
			end else if (!dio_slot) begin
				// Arm only outside a slot so a write never starts mid slot
				write_pend <= ioctl_wait;
			end
		end
	end

	// ========================================
	// Target mapping
	// ========================================
	always_comb begin
		case (ioctl_index)
			DL_FLOPPY_INT: dio_a = 21'(`MAC_FLOPPY0_BASE) + word_addr[20:0];
			DL_FLOPPY_EXT: dio_a = 21'(`MAC_FLOPPY1_BASE) + word_addr[20:0];
			default:       dio_a = word_addr[20:0];
		endcase
	end

	assign req.active = ioctl_download && dio_slot;
	assign req.addr   = {`MAC_ROM_REGION, dio_a};
	assign req.wdata  = word_data;
	assign req.ds     = 2'b11;
	// First cycle of the slot only
	assign req.we     = req.active && write_pend && !slot_q;

	// ========================================
	// End of download
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			download_q <= 1'b0;
			dl_end     <= 1'b0;
		end else begin
			download_q <= ioctl_download;
			dl_end     <= download_q && !ioctl_download;
		end
	end

	// Final host address gives the image size in words
	always_ff @(posedge clk_sys) begin
		if (download_q && !ioctl_download) begin
			dl_index <= ioctl_index;
			dl_words <= ioctl_addr[24:1];
		end
	end

	a_we_in_wait: assert property (@(posedge clk_sys) disable iff (!n_reset)
		req.we |-> req.active && ioctl_wait)
		else $error("word write outside an active download wait");

endmodule

// ==== src/floppy_detect.sv ====
// ========================================
// Floppy image detect
// Recognizes a disk image by its final size
// and clears on eject
// ========================================
`include "mac_settings.svh"
`timescale 1ns/1ps

module floppy_detect #(
	parameter mac_pkg::dl_target_e DRIVE = mac_pkg::DL_FLOPPY_INT
) (
	input  logic                clk_sys,
	input  logic                n_reset,
	input  logic                dl_end,
	input  mac_pkg::dl_target_e dl_index,
	input  mac_pkg::word_addr_t dl_words,
	input  logic                eject,
	output logic                inserted,
	output logic                double_sided
);
	import mac_pkg::*;

	logic ds_flag;
	logic ss_flag;

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			ds_flag <= 1'b0;
			ss_flag <= 1'b0;
		end else if (eject) begin
			// Eject from the OS wins over a finishing download
			ds_flag <= 1'b0;
			ss_flag <= 1'b0;
		end else if (dl_end && dl_index == DRIVE) begin
			// Unknown size leaves the drive empty
			ds_flag <= (dl_words == word_addr_t'(`MAC_FLOPPY_DS_WORDS));
			ss_flag <= (dl_words == word_addr_t'(`MAC_FLOPPY_SS_WORDS));
		end
	end

	assign inserted     = ds_flag || ss_flag;
	assign double_sided = ds_flag;

endmodule

// ==== src/mem_arbiter.sv ====
// ========================================
// SDRAM port arbiter
// Download or chipset owns the port, and
// byte-wide disk reads are demultiplexed
// ========================================
`include "mac_settings.svh"
`timescale 1ns/1ps

module mem_arbiter (
	mem_req_if.arbiter           req,
	input  logic [21:0]          mem_addr,
	input  logic [15:0]          mem_wdata,
	input  logic                 mem_uds,
	input  logic                 mem_lds,
	input  logic                 ram_oe,
	input  logic                 ram_we,
	input  logic                 rom_oe,
	input  logic                 dsk_read_ack,
	input  logic [15:0]          sdram_dout,
	output logic [15:0]          mem_rdata,
	output mac_pkg::sdram_addr_t sdram_addr,
	output logic [15:0]          sdram_din,
	output logic [1:0]           sdram_ds,
	output logic                 sdram_we,
	output logic                 sdram_oe
);
	import mac_pkg::*;

	logic [15:0] disk_byte;
	sdram_addr_t chip_addr;

	// ROM sits in the same region the loader writes
	assign chip_addr = sdram_addr_t'({rom_oe ? `MAC_ROM_REGION : 4'b0000, mem_addr[21:1]});

	// Disk image is byte wide, copy the addressed byte to both halves
	assign disk_byte = mem_addr[0] ? {2{sdram_dout[7:0]}} : {2{sdram_dout[15:8]}};

	// ========================================
	// Port mux
	// ========================================
	assign sdram_addr = req.active ? req.addr  : chip_addr;
	assign sdram_din  = req.active ? req.wdata : mem_wdata;
	assign sdram_ds   = req.active ? req.ds    : {mem_uds, mem_lds};
	assign sdram_we   = req.active ? req.we    : ram_we;
	assign sdram_oe   = req.active ? 1'b0      : (ram_oe || rom_oe);

	// Bus floats high to the chipset while the loader owns it
	assign mem_rdata = req.active   ? 16'hffff  :
	                   dsk_read_ack ? disk_byte : sdram_dout;

	// Chipset must never read and write in one cycle
	always_comb begin
		a_we_oe: assert (!(sdram_we && sdram_oe))
			else $error("SDRAM read and write requested together");
	end

endmodule

// ==== src/mac_board.sv ====
// ========================================
// Mac board top
// System glue, image loader, floppy detect
// and SDRAM arbiter
// ========================================
`include "mac_settings.svh"
`timescale 1ns/1ps

module mac_board #(
	parameter int unsigned RST_LEN  = `MAC_RST_LEN,
	parameter int unsigned LED_HOLD = `MAC_LED_HOLD
) (
	input  logic                 clk_sys,
	input  logic                 n_reset,
	input  logic                 reset_req,
	input  mac_pkg::mem_size_t   mem_size,
	input  logic                 turbo_req,
	input  logic                 dio_slot,
	input  logic                 sd_ack,
	input  logic [1:0]           disk_motor,
	input  logic [1:0]           disk_act,
	input  logic [1:0]           disk_eject,
	// Host download port
	input  logic                 ioctl_download,
	input  mac_pkg::dl_target_e  ioctl_index,
	input  logic                 ioctl_wr,
	input  logic [24:0]          ioctl_addr,
	input  logic [7:0]           ioctl_data,
	output logic                 ioctl_wait,
	// Chipset memory side
	input  logic [21:0]          mem_addr,
	input  logic [15:0]          mem_wdata,
	input  logic                 mem_uds,
	input  logic                 mem_lds,
	input  logic                 ram_oe,
	input  logic                 ram_we,
	input  logic                 rom_oe,
	input  logic                 dsk_read_ack,
	output logic [15:0]          mem_rdata,
	// SDRAM controller side
	input  logic [15:0]          sdram_dout,
	output mac_pkg::sdram_addr_t sdram_addr,
	output logic [15:0]          sdram_din,
	output logic [1:0]           sdram_ds,
	output logic                 sdram_we,
	output logic                 sdram_oe,
	// System outputs
	output logic                 cep,
	output logic                 cen,
	output logic                 ce_pixel,
	output logic                 sys_reset_n,
	output mac_pkg::mem_size_t   ram_size,
	output logic                 turbo,
	output logic                 led_user,
	output logic [1:0]           disk_inserted,
	output logic [1:0]           disk_sides
);
	import mac_pkg::*;

	mem_req_if  dl_req ();

	logic       dl_end;
	dl_target_e dl_index;
	word_addr_t dl_words;

	mac_sys_ctrl #(.RST_LEN(RST_LEN), .LED_HOLD(LED_HOLD)) sys_ctrl_i (
		.clk_sys(clk_sys), .n_reset(n_reset), .reset_req(reset_req),
		.mem_size(mem_size), .turbo_req(turbo_req), .dio_slot(dio_slot),
		.sd_ack(sd_ack), .disk_motor(disk_motor), .disk_act(disk_act),
		.ioctl_download(ioctl_download), .cep(cep), .cen(cen),
		.ce_pixel(ce_pixel), .sys_reset_n(sys_reset_n), .ram_size(ram_size),
		.turbo(turbo), .led_user(led_user)
	);

	rom_loader loader_i (
		.clk_sys(clk_sys), .n_reset(n_reset), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_data(ioctl_data), .dio_slot(dio_slot), .ioctl_wait(ioctl_wait),
		.req(dl_req.loader), .dl_end(dl_end), .dl_index(dl_index),
		.dl_words(dl_words)
	);

	// Internal drive is bit 0, external bit 1
	floppy_detect #(.DRIVE(DL_FLOPPY_INT)) floppy_int_i (
		.clk_sys(clk_sys), .n_reset(n_reset), .dl_end(dl_end),
		.dl_index(dl_index), .dl_words(dl_words), .eject(disk_eject[0]),
		.inserted(disk_inserted[0]), .double_sided(disk_sides[0])
	);

	floppy_detect #(.DRIVE(DL_FLOPPY_EXT)) floppy_ext_i (
		.clk_sys(clk_sys), .n_reset(n_reset), .dl_end(dl_end),
		.dl_index(dl_index), .dl_words(dl_words), .eject(disk_eject[1]),
		.inserted(disk_inserted[1]), .double_sided(disk_sides[1])
	);

	mem_arbiter arbiter_i (
		.req(dl_req.arbiter), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_uds(mem_uds), .mem_lds(mem_lds), .ram_oe(ram_oe), .ram_we(ram_we),
		.rom_oe(rom_oe), .dsk_read_ack(dsk_read_ack), .sdram_dout(sdram_dout),
		.mem_rdata(mem_rdata), .sdram_addr(sdram_addr), .sdram_din(sdram_din),
		.sdram_ds(sdram_ds), .sdram_we(sdram_we), .sdram_oe(sdram_oe)
	);

endmodule

// ==== dv/tb_clk_gen.sv ====
// ========================================
// Testbench clock and reset
// 10 ns clock, reset low for two cycles
// ========================================
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int HALF_NS      = 5,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic n_reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_NS) clk_sys = ~clk_sys;
	end

	// Release just after an edge so the DUT sees a clean level
	initial begin
		n_reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		n_reset = 1'b1;
	end

endmodule

// ==== dv/mac_board_tb.sv ====
// ========================================
// Mac board testbench
// Directed tests for clock enables, reset,
// image loader, floppy detect, chipset path,
// turbo delay and activity light
// ========================================
`include "mac_settings.svh"
`timescale 1ns/1ps

module mac_board_tb;
	import mac_pkg::*;

	localparam int RST_LEN  = 8;
	localparam int LED_HOLD = 200;
	// Whole run needs about 1000 cycles, generous margin on top
	localparam int TIMEOUT_CYCLES = 20000;
	// Reset hold window, RST_LEN cen pulses plus up to one divider period
	localparam int LOW_MIN = RST_LEN * 8;
	localparam int LOW_MAX = RST_LEN * 8 + 8;

	logic                 clk_sys;
	logic                 n_reset;
	logic                 reset_req;
	mem_size_t            mem_size;
	logic                 turbo_req;
	logic                 dio_slot;
	logic                 sd_ack;
	logic [1:0]           disk_motor;
	logic [1:0]           disk_act;
	logic [1:0]           disk_eject;
	logic                 ioctl_download;
	dl_target_e           ioctl_index;
	logic                 ioctl_wr;
	logic [24:0]          ioctl_addr;
	logic [7:0]           ioctl_data;
	logic                 ioctl_wait;
	logic [21:0]          mem_addr;
	logic [15:0]          mem_wdata;
	logic                 mem_uds;
	logic                 mem_lds;
	logic                 ram_oe;
	logic                 ram_we;
	logic                 rom_oe;
	logic                 dsk_read_ack;
	logic [15:0]          mem_rdata;
	logic [15:0]          sdram_dout;
	sdram_addr_t          sdram_addr;
	logic [15:0]          sdram_din;
	logic [1:0]           sdram_ds;
	logic                 sdram_we;
	logic                 sdram_oe;
	logic                 cep;
	logic                 cen;
	logic                 ce_pixel;
	logic                 sys_reset_n;
	mem_size_t            ram_size;
	logic                 turbo;
	logic                 led_user;
	logic [1:0]           disk_inserted;
	logic [1:0]           disk_sides;

	int     errors;
	int     checks;
	int     cycles;
	integer seed;
	logic [1:0] slot_phase = 2'd0;

	tb_clk_gen clk_gen_i (.clk_sys(clk_sys), .n_reset(n_reset));

	mac_board #(.RST_LEN(RST_LEN), .LED_HOLD(LED_HOLD)) mac_board_i (.*);

	// Chipset slot, one cycle in every four
	always @(posedge clk_sys) begin
		#1;
		slot_phase = slot_phase + 2'd1;
		dio_slot = (slot_phase == 2'd0);
	end

	// ========================================
	// Helpers
	// ========================================
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic expect_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("At %0t ns: %s", $time, msg);
	endtask

	// Pulse reset_req and count cycles with sys_reset_n low
	task automatic reset_and_wait(output int low_cycles);
		next_cycle();
		reset_req = 1'b1;
		next_cycle();
		reset_req = 1'b0;
		low_cycles = 0;
		while (!sys_reset_n && low_cycles < 200) begin
			low_cycles++;
			next_cycle();
		end
		if (!sys_reset_n)
			note_failure("sys_reset_n did not rise after reset_req");
	endtask

	// High byte then low byte, then hold off while ioctl_wait is up
	task automatic send_word(input int unsigned word, input logic [15:0] data,
			input logic [24:0] exp_addr);
		int strobes;
		int waited;
		next_cycle();
		ioctl_addr = 25'(word * 2);
		ioctl_data = data[15:8];
		ioctl_wr   = 1'b1;
		next_cycle();
		ioctl_addr = 25'(word * 2 + 1);
		ioctl_data = data[7:0];
		next_cycle();
		ioctl_wr = 1'b0;
		strobes  = 0;
		waited   = 0;
		do begin
			@(negedge clk_sys);
			if (sdram_we) begin
				strobes++;
				expect_equal("download sdram_addr", 32'(sdram_addr), 32'(exp_addr));
				expect_equal("download sdram_din", 32'(sdram_din), 32'(data));
				expect_equal("download sdram_ds", 32'(sdram_ds), 32'd3);
				expect_equal("download sdram_oe", 32'(sdram_oe), 32'd0);
				expect_equal("download mem_rdata", 32'(mem_rdata), 32'hffff);
			end
			waited++;
		end while (ioctl_wait && waited < 40);
		if (ioctl_wait)
			note_failure("ioctl_wait stayed high after a word write");
		expect_equal("sdram_we strobes per word", 32'(strobes), 32'd1);
	endtask

	// Drop ioctl_download and let dl_end reach the floppy flags
	task automatic end_download();
		next_cycle();
		ioctl_download = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	// Download with no bytes, only the final address matters
	task automatic load_image(input dl_target_e idx, input int unsigned words);
		next_cycle();
		ioctl_index    = idx;
		ioctl_addr     = 25'(words * 2);
		ioctl_download = 1'b1;
		end_download();
	endtask

	task automatic eject_drive(input int drive);
		next_cycle();
		disk_eject[drive] = 1'b1;
		next_cycle();
		disk_eject = 2'b00;
	endtask

	// One sd_ack pulse per falling edge
	task automatic ack_falls(input int n);
		repeat (n) begin
			next_cycle();
			sd_ack = 1'b1;
			next_cycle();
			sd_ack = 1'b0;
		end
		next_cycle();
	endtask

	task automatic wait_turbo(input logic level);
		int n;
		n = 0;
		while (turbo !== level && n < 8) begin
			next_cycle();
			n++;
		end
		expect_equal("turbo follows turbo_req", 32'(turbo), 32'(level));
		// Next slot is at most four cycles away
		expect_equal("turbo switch within one slot period", 32'(n <= 4), 32'd1);
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic clocks_and_reset();
		int n;
		int pulses;
		int low_cycles;
		n = 0;
		while (!cep && n < 16) begin
			next_cycle();
			n++;
		end
		expect_equal("cep found", 32'(cep), 32'd1);
		expect_equal("ce_pixel with cep", 32'(ce_pixel), 32'd1);
		repeat (2) next_cycle();
		expect_equal("ce_pixel off between", 32'(ce_pixel), 32'd0);
		repeat (2) next_cycle();
		expect_equal("cen 4 cycles after cep", 32'(cen), 32'd1);
		expect_equal("cep low at cen", 32'(cep), 32'd0);
		expect_equal("ce_pixel with cen", 32'(ce_pixel), 32'd1);
		repeat (4) next_cycle();
		expect_equal("cep after 8 cycles", 32'(cep), 32'd1);
		pulses = 0;
		repeat (64) begin
			next_cycle();
			if (cep)
				pulses++;
		end
		expect_equal("cep pulses in 64 cycles", 32'(pulses), 32'd8);
		// Size code steps up by one and wraps
		for (int i = 0; i < 2; i++) begin
			mem_size = mem_size_t'(i + 2);
			reset_and_wait(low_cycles);
			expect_equal("sys_reset_n low length in range",
				32'(low_cycles >= LOW_MIN && low_cycles <= LOW_MAX), 32'd1);
			expect_equal("ram_size", 32'(ram_size), 32'((i + 3) % 4));
		end
	endtask

	task automatic rom_download();
		logic [15:0] data;
		int unsigned base;
		int unsigned first;
		int unsigned count;
		for (int pass = 0; pass < 2; pass++) begin
			next_cycle();
			ioctl_index    = (pass == 0) ? DL_OS_ROM : DL_FLOPPY_EXT;
			base           = (pass == 0) ? 0 : `MAC_FLOPPY1_BASE;
			first          = (pass == 0) ? 0 : 'h40;
			count          = (pass == 0) ? 4 : 3;
			ioctl_download = 1'b1;
			for (int w = 0; w < int'(count); w++) begin
				data = 16'($random(seed));
				send_word(first + w, data, {`MAC_ROM_REGION, 21'(base + first + w)});
			end
			end_download();
		end
	endtask

	task automatic floppy_detection();
		load_image(DL_FLOPPY_INT, 409600);
		expect_equal("inserted after DS image", 32'(disk_inserted), 32'b01);
		expect_equal("sides after DS image", 32'(disk_sides), 32'b01);
		load_image(DL_FLOPPY_EXT, 204800);
		expect_equal("inserted after SS image", 32'(disk_inserted), 32'b11);
		expect_equal("sides after SS image", 32'(disk_sides), 32'b01);
		eject_drive(0);
		expect_equal("inserted after eject 0", 32'(disk_inserted), 32'b10);
		expect_equal("sides after eject 0", 32'(disk_sides), 32'b00);
		load_image(DL_FLOPPY_INT, 300000);
		expect_equal("inserted after odd size", 32'(disk_inserted), 32'b10);
		eject_drive(1);
		expect_equal("inserted after eject 1", 32'(disk_inserted), 32'b00);
		// Unknown size replaces a good image
		load_image(DL_FLOPPY_INT, 204800);
		expect_equal("inserted before replace", 32'(disk_inserted), 32'b01);
		load_image(DL_FLOPPY_INT, 204801);
		expect_equal("inserted after bad replace", 32'(disk_inserted), 32'b00);
		expect_equal("sides after bad replace", 32'(disk_sides), 32'b00);
	endtask

	task automatic chipset_path();
		logic [21:0] addr;
		for (int i = 0; i < 6; i++) begin
			next_cycle();
			addr         = 22'($random(seed));
			mem_addr     = addr;
			mem_wdata    = 16'($random(seed));
			sdram_dout   = 16'($random(seed));
			mem_uds      = addr[1];
			mem_lds      = addr[2];
			ram_oe       = (i % 3 == 0);
			rom_oe       = (i % 3 == 1);
			ram_we       = (i % 3 == 2);
			dsk_read_ack = 1'b0;
			@(negedge clk_sys);
			expect_equal("chip sdram_addr", 32'(sdram_addr),
				32'({3'b000, rom_oe, addr[21:1]}));
			expect_equal("chip sdram_din", 32'(sdram_din), 32'(mem_wdata));
			expect_equal("chip sdram_ds", 32'(sdram_ds), 32'({mem_uds, mem_lds}));
			expect_equal("chip sdram_we", 32'(sdram_we), 32'(ram_we));
			expect_equal("chip sdram_oe", 32'(sdram_oe), 32'(ram_oe | rom_oe));
			expect_equal("chip mem_rdata", 32'(mem_rdata), 32'(sdram_dout));
		end
		// Disk reads pick one byte and copy it
		for (int b = 0; b < 2; b++) begin
			next_cycle();
			mem_addr     = {21'($random(seed)), b[0]};
			sdram_dout   = 16'($random(seed));
			ram_oe       = 1'b1;
			rom_oe       = 1'b0;
			ram_we       = 1'b0;
			dsk_read_ack = 1'b1;
			@(negedge clk_sys);
			expect_equal("disk byte read", 32'(mem_rdata), (b == 0) ?
				32'({sdram_dout[15:8], sdram_dout[15:8]}) :
				32'({sdram_dout[7:0], sdram_dout[7:0]}));
		end
		next_cycle();
		ram_oe       = 1'b0;
		dsk_read_ack = 1'b0;
	endtask

	task automatic turbo_delay();
		int low_cycles;
		turbo_req = 1'b1;
		reset_and_wait(low_cycles);
		ack_falls(19);
		repeat (8) next_cycle();
		expect_equal("turbo held before 20 acks", 32'(turbo), 32'd0);
		ack_falls(1);
		wait_turbo(1'b1);
		turbo_req = 1'b0;
		wait_turbo(1'b0);
		// Motor pulse part way through restarts the count
		turbo_req = 1'b1;
		reset_and_wait(low_cycles);
		ack_falls(15);
		disk_motor = 2'b01;
		next_cycle();
		disk_motor = 2'b00;
		ack_falls(15);
		repeat (8) next_cycle();
		expect_equal("turbo held after motor restart", 32'(turbo), 32'd0);
		ack_falls(5);
		wait_turbo(1'b1);
		turbo_req = 1'b0;
		wait_turbo(1'b0);
	endtask

	task automatic activity_light();
		int lit;
		next_cycle();
		expect_equal("led off when idle", 32'(led_user), 32'd0);
		disk_act = 2'b10;
		next_cycle();
		disk_act = 2'b00;
		lit = 0;
		while (led_user && lit < 400) begin
			lit++;
			next_cycle();
		end
		expect_equal("led hold length in range",
			32'(lit >= LED_HOLD - 2 && lit <= LED_HOLD + 2), 32'd1);
		// Download keeps the light on
		ioctl_index    = DL_OS_ROM;
		ioctl_addr     = '0;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		expect_equal("led during download", 32'(led_user), 32'd1);
		end_download();
		expect_equal("led after download", 32'(led_user), 32'd0);
		// Motor on flips the light
		disk_motor = 2'b01;
		@(negedge clk_sys);
		expect_equal("led with motor only", 32'(led_user), 32'd1);
		next_cycle();
		disk_act = 2'b01;
		next_cycle();
		disk_act = 2'b00;
		repeat (3) next_cycle();
		expect_equal("led with motor and activity", 32'(led_user), 32'd0);
		disk_motor = 2'b00;
		@(negedge clk_sys);
		expect_equal("led with activity only", 32'(led_user), 32'd1);
	endtask

	// ========================================
	// Run control
	// ========================================
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		int n;
		errors         = 0;
		checks         = 0;
		seed           = 67524;
		reset_req      = 1'b0;
		mem_size       = 2'd0;
		turbo_req      = 1'b0;
		dio_slot       = 1'b0;
		sd_ack         = 1'b0;
		disk_motor     = 2'b00;
		disk_act       = 2'b00;
		disk_eject     = 2'b00;
		ioctl_download = 1'b0;
		ioctl_index    = DL_OS_ROM;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		mem_addr       = '0;
		mem_wdata      = '0;
		mem_uds        = 1'b0;
		mem_lds        = 1'b0;
		ram_oe         = 1'b0;
		ram_we         = 1'b0;
		rom_oe         = 1'b0;
		dsk_read_ack   = 1'b0;
		sdram_dout     = '0;
		while (!n_reset)
			@(posedge clk_sys);
		next_cycle();
		// Outputs idle straight out of reset
		expect_equal("sys_reset_n after reset", 32'(sys_reset_n), 32'd0);
		expect_equal("turbo after reset", 32'(turbo), 32'd0);
		expect_equal("ioctl_wait after reset", 32'(ioctl_wait), 32'd0);
		expect_equal("sdram_we after reset", 32'(sdram_we), 32'd0);
		expect_equal("disk_inserted after reset", 32'(disk_inserted), 32'd0);
		n = 0;
		while (!sys_reset_n && n < 200) begin
			next_cycle();
			n++;
		end
		if (!sys_reset_n)
			note_failure("sys_reset_n did not rise after power-on reset");
		clocks_and_reset();
		rom_download();
		floppy_detection();
		chipset_path();
		turbo_delay();
		activity_light();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+src
src/mac_pkg.sv
src/mem_req_if.sv
src/mac_sys_ctrl.sv
src/rom_loader.sv
src/floppy_detect.sv
src/mem_arbiter.sv
src/mac_board.sv
dv/tb_clk_gen.sv
dv/mac_board_tb.sv

// ==== Makefile ====
TOP := mac_board_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
